/* include/fp_add_macros.svh */
// ====================
// Single precision format constants for the FP adder
// ====================

`ifndef FP_ADD_MACROS_SVH
`define FP_ADD_MACROS_SVH

// Field widths
`define FP_EXP_W 8
`define FP_MAN_W 23
`define FP_WORD_W 32

// Exponent value of infinity and NaN
`define FP_EXP_MAX 255

// Guard, round and sticky below the mantissa lsb
`define FP_GRS_W 3

// Quiet NaN returned for every invalid operation
`define FP_CANON_NAN 32'h7FC0_0000

`endif

/* rtl/fp_format_pkg.sv */
// ====================
// Operand word layout of the FP adder
// ====================

`include "fp_add_macros.svh"

package fp_format_pkg;

  // ====================
  // Field view
  // ====================
  typedef struct packed {
    logic                 sign;
    logic [`FP_EXP_W-1:0] exp;  // Biased exponent
    logic [`FP_MAN_W-1:0] man;  // Stored fraction, hidden bit not included
  } fp_fields_t;

  // ====================
  // One word, two readings
  // ====================
  // Raw bits for transport and compare, fields for decode and packing
  typedef union packed {
    logic [`FP_WORD_W-1:0] raw;
    fp_fields_t            fields;
  } fp_word_u;

endpackage

/* rtl/fp_round_pkg.sv */
// ====================
// Rounding mode codes of the FP adder
// ====================

package fp_round_pkg;

  // Same encoding as the RISC-V frm field
  localparam logic [2:0] RM_RNE = 3'd0;  // Nearest, ties to even
  localparam logic [2:0] RM_RTZ = 3'd1;  // Toward zero
  localparam logic [2:0] RM_RDN = 3'd2;  // Toward minus infinity
  localparam logic [2:0] RM_RUP = 3'd3;  // Toward plus infinity
  localparam logic [2:0] RM_RMM = 3'd4;  // Nearest, ties away from zero

  // Codes 5 to 7 fall back to truncation

endpackage

/* rtl/fp_add_sequencer.sv */
// ====================
// FP adder sequencer
// Captures the operands and steps the datapath stages
// ====================

`timescale 1ns/10ps

`include "fp_add_macros.svh"

module fp_add_sequencer (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  start,
  input  logic                  is_sub,
  input  logic [2:0]            rounding_mode,
  input  logic [`FP_WORD_W-1:0] operand_a,
  input  logic [`FP_WORD_W-1:0] operand_b,
  output logic                  busy,
  output logic                  done,
  output logic                  align_en,
  output logic                  add_en,
  output logic                  norm_en,
  output logic                  round_en,
  output logic [`FP_WORD_W-1:0] op_a,
  output logic [`FP_WORD_W-1:0] op_b,
  output logic [2:0]            rmode
);

  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_LOAD  = 3'd1;  // Operands held, nothing computed yet
  localparam logic [2:0] ST_ALIGN = 3'd2;
  localparam logic [2:0] ST_ADD   = 3'd3;
  localparam logic [2:0] ST_NORM  = 3'd4;
  localparam logic [2:0] ST_ROUND = 3'd5;
  localparam logic [2:0] ST_DONE  = 3'd6;

  logic [2:0] stage;
  logic       accept;

  assign accept = start && !busy;  // Also taken in the done cycle

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      stage <= ST_IDLE;
    end else if (accept) begin
      stage <= ST_LOAD;
    end else if (stage == ST_DONE) begin
      stage <= ST_IDLE;
    end else if (stage != ST_IDLE) begin
      stage <= stage + 3'd1;
    end
  end

  // Subtract is an add with b negated
  always_ff @(posedge clk) begin
    if (accept) begin
      op_a  <= operand_a;
      op_b  <= {operand_b[`FP_WORD_W-1] ^ is_sub, operand_b[`FP_WORD_W-2:0]};
      rmode <= rounding_mode;
    end
  end

  assign busy     = (stage != ST_IDLE) && (stage != ST_DONE);
  assign done     = (stage == ST_DONE);
  assign align_en = (stage == ST_ALIGN);
  assign add_en   = (stage == ST_ADD);
  assign norm_en  = (stage == ST_NORM);
  assign round_en = (stage == ST_ROUND);

  // Single-cycle done pulse, outside the busy window
  a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    done |-> (!busy ##1 !done));

endmodule

/* rtl/fp_special_case.sv */
// ====================
// FP adder special cases
// Decodes NaN, infinity and zero operands into a ready result
// ====================

`timescale 1ns/10ps

`include "fp_add_macros.svh"

module fp_special_case (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  align_en,
  input  logic [`FP_WORD_W-1:0] op_a,
  input  logic [`FP_WORD_W-1:0] op_b,
  input  logic [2:0]            rmode,
  output logic                  special_hit,
  output logic [`FP_WORD_W-1:0] special_word,
  output logic                  special_nv
);

  fp_format_pkg::fp_word_u ua;
  fp_format_pkg::fp_word_u ub;
  fp_format_pkg::fp_word_u word;
  logic nan_a, nan_b, inf_a, inf_b, zero_a, zero_b;
  logic zero_sign;
  logic hit;
  logic nv;

  assign ua = op_a;
  assign ub = op_b;  // Sign already holds the subtract

  // ====================
  // Classification
  // ====================
  assign nan_a  = (ua.fields.exp == `FP_EXP_MAX) && (ua.fields.man != '0);
  assign nan_b  = (ub.fields.exp == `FP_EXP_MAX) && (ub.fields.man != '0);
  assign inf_a  = (ua.fields.exp == `FP_EXP_MAX) && (ua.fields.man == '0);
  assign inf_b  = (ub.fields.exp == `FP_EXP_MAX) && (ub.fields.man == '0);
  assign zero_a = (ua.fields.exp == '0);  // Subnormals flushed to zero
  assign zero_b = (ub.fields.exp == '0);

  // -0 only when both are negative, or either is in round down
  assign zero_sign = (rmode == fp_round_pkg::RM_RDN) ?
                     (ua.fields.sign | ub.fields.sign) :
                     (ua.fields.sign & ub.fields.sign);

  always_comb begin
    hit      = 1'b1;
    nv       = 1'b0;
    word.raw = `FP_CANON_NAN;
    if (nan_a || nan_b) begin
      nv = 1'b1;
    end else if (inf_a && inf_b && (ua.fields.sign != ub.fields.sign)) begin
      nv = 1'b1;  // Inf minus inf
    end else if (inf_a) begin
      word = ua;
    end else if (inf_b) begin
      word = ub;
    end else if (zero_a && zero_b) begin
      word.raw         = '0;
      word.fields.sign = zero_sign;
    end else if (zero_a) begin
      word = ub;
    end else if (zero_b) begin
      word = ua;
    end else begin
      hit = 1'b0;  // Normal pair, magnitude path owns it
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      special_hit <= 1'b0;
      special_nv  <= 1'b0;
    end else if (align_en) begin
      special_hit <= hit;
      special_nv  <= nv;
    end
  end

  always_ff @(posedge clk) begin
    if (align_en) begin
      special_word <= word.raw;
    end
  end

  a_nv_is_nan: assert property (@(posedge clk) disable iff (!reset_n)
    special_nv |-> (special_word == `FP_CANON_NAN));

endmodule

/* rtl/fp_mag_path.sv */
// ====================
// FP adder magnitude path
// Align, add or subtract, then normalize the significands
// ====================

`timescale 1ns/10ps

`include "fp_add_macros.svh"

module fp_mag_path (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     align_en,
  input  logic                     add_en,
  input  logic                     norm_en,
  input  logic [`FP_WORD_W-1:0]    op_a,
  input  logic [`FP_WORD_W-1:0]    op_b,
  output logic                     res_sign,
  output logic signed [`FP_EXP_W:0] res_exp,
  output logic [`FP_MAN_W:0]       res_man,
  output logic                     guard,
  output logic                     round_bit,
  output logic                     sticky,
  output logic                     sum_zero,
  output logic                     tiny
);

  localparam int MANT_W  = `FP_MAN_W + 1;         // With hidden bit
  localparam int ALIGN_W = MANT_W + `FP_GRS_W;   // 27
  localparam int LZ_W    = $clog2(ALIGN_W + 1);

  fp_format_pkg::fp_word_u ua;
  fp_format_pkg::fp_word_u ub;
  logic [ALIGN_W-1:0]   ma, mb, m_small, shifted;
  logic [`FP_EXP_W-1:0] diff;
  logic                 a_big;
  logic                 lost;

  logic [ALIGN_W-1:0]   al_x, al_y;  // al_x never shifted unless a is smaller
  logic                 sign_x, sign_y;
  logic [`FP_EXP_W-1:0] exp_big;
  logic [ALIGN_W:0]     sum;         // Extra top bit for the carry

  logic [LZ_W-1:0]          lz;
  logic [ALIGN_W-1:0]       norm;
  logic signed [`FP_EXP_W:0] exp_ext;

  assign ua = op_a;
  assign ub = op_b;

  // ====================
  // Align
  // ====================
  always_comb begin
    ma      = {1'b1, ua.fields.man, {`FP_GRS_W{1'b0}}};
    mb      = {1'b1, ub.fields.man, {`FP_GRS_W{1'b0}}};
    a_big   = (ua.fields.exp >= ub.fields.exp);
    diff    = a_big ? (ua.fields.exp - ub.fields.exp) : (ub.fields.exp - ua.fields.exp);
    m_small = a_big ? mb : ma;
    // Anything pushed past bit 0 lands in the sticky, 27+ leaves just that
    lost    = |(m_small & ~({ALIGN_W{1'b1}} << diff));
    shifted = (m_small >> diff) | {{(ALIGN_W-1){1'b0}}, lost};
  end

  always_ff @(posedge clk) begin
    if (align_en) begin
      al_x    <= a_big ? ma : shifted;
      al_y    <= a_big ? shifted : mb;
      sign_x  <= ua.fields.sign;
      sign_y  <= ub.fields.sign;
      exp_big <= a_big ? ua.fields.exp : ub.fields.exp;
    end
  end

  // ====================
  // Add or subtract
  // ====================
  always_ff @(posedge clk) begin
    if (add_en) begin
      if (sign_x == sign_y) begin
        sum      <= {1'b0, al_x} + {1'b0, al_y};
        res_sign <= sign_x;
      end else if (al_x >= al_y) begin
        sum      <= {1'b0, al_x} - {1'b0, al_y};
        res_sign <= sign_x;
      end else begin
        sum      <= {1'b0, al_y} - {1'b0, al_x};
        res_sign <= sign_y;  // Larger magnitude wins the sign
      end
    end
  end

  assign sum_zero = (sum == '0);

  // ====================
  // Normalize
  // ====================
  always_comb begin
    lz = LZ_W'(ALIGN_W);
    for (int i = 0; i < ALIGN_W; i++) begin
      if (sum[i]) lz = LZ_W'(ALIGN_W - 1 - i);  // Highest set bit wins
    end
    norm = sum[ALIGN_W-1:0] << lz;
  end

  assign exp_ext = $signed({1'b0, exp_big});

  always_ff @(posedge clk) begin
    if (norm_en) begin
      if (sum[ALIGN_W]) begin  // Carry out, shift right by one
        res_man   <= sum[ALIGN_W -: MANT_W];
        guard     <= sum[`FP_GRS_W];
        round_bit <= sum[`FP_GRS_W-1];
        sticky    <= |sum[`FP_GRS_W-2:0];
        res_exp   <= exp_ext + 9'sd1;
      end else begin
        res_man   <= norm[ALIGN_W-1 -: MANT_W];
        guard     <= norm[`FP_GRS_W-1];
        round_bit <= norm[`FP_GRS_W-2];
        sticky    <= norm[0];
        res_exp   <= exp_ext - $signed({{(`FP_EXP_W+1-LZ_W){1'b0}}, lz});
      end
    end
  end

  assign tiny = (res_exp <= 9'sd0);  // Below the normal range

  a_norm_msb: assert property (@(posedge clk) disable iff (!reset_n)
    (norm_en && (sum != '0)) |=> res_man[MANT_W-1]);

endmodule

/* rtl/fp_round_pack.sv */
// ====================
// FP adder round and pack
// Rounds the normalized value and picks the final word and flags
// ====================

`timescale 1ns/10ps

`include "fp_add_macros.svh"

module fp_round_pack (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      round_en,
  input  logic [2:0]                rmode,
  input  logic                      special_hit,
  input  logic [`FP_WORD_W-1:0]     special_word,
  input  logic                      special_nv,
  input  logic                      res_sign,
  input  logic signed [`FP_EXP_W:0] res_exp,
  input  logic [`FP_MAN_W:0]        res_man,
  input  logic                      guard,
  input  logic                      round_bit,
  input  logic                      sticky,
  input  logic                      sum_zero,
  input  logic                      tiny,
  output logic [`FP_WORD_W-1:0]     result,
  output logic                      flag_nv,
  output logic                      flag_of,
  output logic                      flag_nx
);

  localparam logic signed [`FP_EXP_W:0] EXP_TOP = `FP_EXP_MAX;

  fp_format_pkg::fp_word_u word;
  fp_format_pkg::fp_word_u res_u;
  logic                  inexact;
  logic                  round_up;
  logic [`FP_WORD_W-2:0] rounded;  // Exponent and fraction together
  logic                  ovf;
  logic                  nxt_nv, nxt_of, nxt_nx;

  // ====================
  // Rounding
  // ====================
  assign inexact = guard | round_bit | sticky;

  always_comb begin
    case (rmode)
      fp_round_pkg::RM_RNE: round_up = guard & (round_bit | sticky | res_man[0]);
      fp_round_pkg::RM_RDN: round_up = res_sign & inexact;
      fp_round_pkg::RM_RUP: round_up = ~res_sign & inexact;
      fp_round_pkg::RM_RMM: round_up = guard;
      default:              round_up = 1'b0;  // RTZ and unused codes
    endcase
  end

  // Fraction carry ripples into the exponent
  assign rounded = {res_exp[`FP_EXP_W-1:0], res_man[`FP_MAN_W-1:0]} +
                   {{(`FP_WORD_W-2){1'b0}}, round_up};
  assign ovf = (res_exp >= EXP_TOP) || (&rounded[`FP_WORD_W-2 -: `FP_EXP_W]);

  // ====================
  // Result select
  // ====================
  always_comb begin
    word.raw = '0;
    nxt_nv   = 1'b0;
    nxt_of   = 1'b0;
    nxt_nx   = 1'b0;
    if (special_hit) begin
      word.raw = special_word;
      nxt_nv   = special_nv;
    end else if (sum_zero) begin
      word.fields.sign = (rmode == fp_round_pkg::RM_RDN);  // Exact cancellation
    end else if (tiny) begin
      word.fields.sign = res_sign;  // Flushed, no subnormals
      nxt_nx           = 1'b1;
    end else if (ovf) begin
      word.fields.sign = res_sign;
      word.fields.exp  = '1;
      nxt_of           = 1'b1;
      nxt_nx           = 1'b1;
    end else begin
      word.raw = {res_sign, rounded};
      nxt_nx   = inexact;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      result  <= '0;
      flag_nv <= 1'b0;
      flag_of <= 1'b0;
      flag_nx <= 1'b0;
    end else if (round_en) begin
      result  <= word.raw;
      flag_nv <= nxt_nv;
      flag_of <= nxt_of;
      flag_nx <= nxt_nx;
    end
  end

  // NaN payloads from the inputs never leak out
  assign res_u = result;

  a_canon_nan: assert property (@(posedge clk) disable iff (!reset_n)
    ((res_u.fields.exp == `FP_EXP_MAX) && (res_u.fields.man != '0)) |->
    (result == `FP_CANON_NAN));

endmodule

/* rtl/fp_add_top.sv */
// ====================
// Multi-cycle single precision FP adder and subtractor
// ====================

`timescale 1ns/10ps

`include "fp_add_macros.svh"

module fp_add_top (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  start,
  input  logic                  is_sub,
  input  logic [2:0]            rounding_mode,
  input  logic [`FP_WORD_W-1:0] operand_a,
  input  logic [`FP_WORD_W-1:0] operand_b,
  output logic                  busy,
  output logic                  done,
  output logic [`FP_WORD_W-1:0] result,
  output logic                  flag_nv,
  output logic                  flag_of,
  output logic                  flag_nx
);

  // Stage strobes and captured operands
  logic                  align_en, add_en, norm_en, round_en;
  logic [`FP_WORD_W-1:0] op_a, op_b;
  logic [2:0]            rmode;

  // Special-case result
  logic                  special_hit, special_nv;
  logic [`FP_WORD_W-1:0] special_word;

  // Normalized magnitude
  logic                      res_sign;
  logic signed [`FP_EXP_W:0] res_exp;
  logic [`FP_MAN_W:0]        res_man;
  logic                      guard, round_bit, sticky, sum_zero, tiny;

  fp_add_sequencer u_seq (
    .clk, .reset_n, .start, .is_sub, .rounding_mode, .operand_a, .operand_b,
    .busy, .done, .align_en, .add_en, .norm_en, .round_en, .op_a, .op_b, .rmode
  );

  fp_special_case u_special (
    .clk, .reset_n, .align_en, .op_a, .op_b, .rmode,
    .special_hit, .special_word, .special_nv
  );

  fp_mag_path u_mag (
    .clk, .reset_n, .align_en, .add_en, .norm_en, .op_a, .op_b,
    .res_sign, .res_exp, .res_man, .guard, .round_bit, .sticky, .sum_zero, .tiny
  );

  fp_round_pack u_round (
    .clk, .reset_n, .round_en, .rmode, .special_hit, .special_word, .special_nv,
    .res_sign, .res_exp, .res_man, .guard, .round_bit, .sticky, .sum_zero, .tiny,
    .result, .flag_nv, .flag_of, .flag_nx
  );

endmodule

/* verification/tb_clock_gen.sv */
// ====================
// Testbench clock and reset
// ====================

`timescale 1ns/10ps

module tb_clock_gen #(
  parameter real PERIOD       = 40.0,
  parameter int  RESET_CYCLES = 4
) (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 reset_n = 1'b1;  // Released clear of the edge
  end

endmodule

/* verification/fp_add_model.svh */
// ====================
// FP adder reference model and LFSR random source
// Included inside the testbench top
// ====================

`ifndef FP_ADD_MODEL_SVH
`define FP_ADD_MODEL_SVH

`include "fp_add_macros.svh"

logic [31:0] lfsr_state = 32'h46b2a86b;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = {lfsr_state[30:0],
                  lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

// ====================
// Reference add, returns {nv, of, nx, result}
// ====================
function automatic logic [34:0] fp_add_ref(input logic [31:0] a_raw, input logic [31:0] b_raw,
                                           input logic is_sub, input logic [2:0] rm);
  fp_format_pkg::fp_word_u a, b, big, lesser, r;
  logic        nv, of, nx, up, g, rb, st, a_nan, b_nan, a_inf, b_inf;
  logic [27:0] mb, ms, mag;  // Carry, hidden bit, fraction, three extra bits
  logic [30:0] em;
  int          d, e;
  a.raw = a_raw;
  b.raw = b_raw;
  b.fields.sign = b.fields.sign ^ is_sub;  // Effective sign of b
  r.raw = '0;
  {nv, of, nx} = 3'b000;
  a_nan = (a.fields.exp == 8'hFF) && (a.fields.man != 0);
  b_nan = (b.fields.exp == 8'hFF) && (b.fields.man != 0);
  a_inf = (a.fields.exp == 8'hFF) && (a.fields.man == 0);
  b_inf = (b.fields.exp == 8'hFF) && (b.fields.man == 0);
  if (a_nan || b_nan || (a_inf && b_inf && (a.fields.sign != b.fields.sign))) begin
    r.raw = `FP_CANON_NAN;
    nv    = 1'b1;
  end else if (a_inf || b_inf) begin
    r = a_inf ? a : b;
  end else if ((a.fields.exp == 0) && (b.fields.exp == 0)) begin
    r.fields.sign = (rm == fp_round_pkg::RM_RDN) ? (a.fields.sign | b.fields.sign) :
                                                   (a.fields.sign & b.fields.sign);
  end else if ((a.fields.exp == 0) || (b.fields.exp == 0)) begin
    r = (a.fields.exp == 0) ? b : a;
  end else begin
    big    = (a.raw[30:0] >= b.raw[30:0]) ? a : b;  // Larger magnitude first
    lesser = (a.raw[30:0] >= b.raw[30:0]) ? b : a;
    d  = big.fields.exp - lesser.fields.exp;
    mb = {2'b01, big.fields.man, 3'b000};
    ms = {2'b01, lesser.fields.man, 3'b000};
    if (d >= 27) begin
      ms = 28'd1;
    end else if (d > 0) begin
      ms = (ms >> d) | ((ms & ((28'd1 << d) - 28'd1)) != 0);
    end
    mag = (big.fields.sign == lesser.fields.sign) ? (mb + ms) : (mb - ms);
    e   = big.fields.exp;
    if (mag == 0) begin
      r.fields.sign = (rm == fp_round_pkg::RM_RDN);
    end else begin
      if (mag[27]) begin
        mag = (mag >> 1) | mag[0];  // Keep the sticky
        e   = e + 1;
      end
      while (!mag[26]) begin
        mag = mag << 1;
        e   = e - 1;
      end
      g  = mag[2];
      rb = mag[1];
      st = mag[0];
      r.fields.sign = big.fields.sign;
      if (e <= 0) begin
        nx = 1'b1;  // Flushed to a signed zero
      end else if (e >= 255) begin
        r.fields.exp = 8'hFF;
        {of, nx}     = 2'b11;
      end else begin
        case (rm)
          fp_round_pkg::RM_RNE: up = g & (rb | st | mag[3]);
          fp_round_pkg::RM_RDN: up = big.fields.sign & (g | rb | st);
          fp_round_pkg::RM_RUP: up = !big.fields.sign & (g | rb | st);
          fp_round_pkg::RM_RMM: up = g;
          default:              up = 1'b0;
        endcase
        em = {e[7:0], mag[25:3]} + up;
        if (em[30:23] == 8'hFF) begin
          r.fields.exp = 8'hFF;
          {of, nx}     = 2'b11;
        end else begin
          r.raw = {big.fields.sign, em};
          nx    = g | rb | st;
        end
      end
    end
  end
  return {nv, of, nx, r.raw};
endfunction

`endif

/* verification/tb_fp_add.sv */
// ====================
// FP adder testbench
// Random and directed operations checked against a reference model
// ====================

`timescale 1ns/10ps

`include "fp_add_macros.svh"

module tb_fp_add;

  localparam int  N_RANDOM   = 300;
  localparam int  N_SPECIAL  = 200;
  localparam int  TOTAL_OPS  = 1 + N_RANDOM + 60 + N_SPECIAL + 60 + 1;
  localparam int  LATENCY    = 5;  // Edges from the start edge to done
  localparam real TIMEOUT_NS = TOTAL_OPS * 8 * 40.0 + 200 * 40.0;

  logic        clk, reset_n, start, is_sub, busy, done, flag_nv, flag_of, flag_nx;
  logic [2:0]  rounding_mode;
  logic [31:0] operand_a, operand_b, result;
  int          errors, checks, ops, tests, ops_mark, err_mark;

  int          shift_list[5] = '{0, 1, 26, 27, 40};
  logic [31:0] edge_a[6] = '{32'h7F7F_FFFF, 32'h7F00_0000, 32'h7F7F_FFFF,
                             32'h0080_0001, 32'h0100_0000, 32'h00C0_0000};
  logic [31:0] edge_b[6] = '{32'h7F7F_FFFF, 32'h7F00_0001, 32'h7300_0000,
                             32'h0080_0000, 32'h00FF_FFFF, 32'h0080_0001};

  `include "fp_add_model.svh"

  tb_clock_gen clock_gen (.clk, .reset_n);

  fp_add_top UUT (
    .clk, .reset_n, .start, .is_sub, .rounding_mode, .operand_a, .operand_b,
    .busy, .done, .result, .flag_nv, .flag_of, .flag_nx
  );

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  // One operation, optionally with a second start pulse while busy
  task automatic run_op(input logic [31:0] a, input logic [31:0] b, input logic sub,
                        input logic [2:0] rm, input logic poke);
    logic [34:0] want;
    string       msg;
    int          edges;
    want = fp_add_ref(a, b, sub, rm);
    msg  = $sformatf("%h %s %h rm %0d", a, sub ? "-" : "+", b, rm);
    @(posedge clk);
    #2;
    start         = 1'b1;
    is_sub        = sub;
    rounding_mode = rm;
    operand_a     = a;
    operand_b     = b;
    @(posedge clk);  // Start edge
    #2 start = 1'b0;
    edges = 0;
    @(negedge clk);
    while (!done) begin
      check({msg, " busy"}, busy, 1);
      @(posedge clk);
      edges++;
      #2;
      start = poke && (edges == 1);
      if (poke) begin
        operand_a = ~a;
        operand_b = ~b;
      end
      @(negedge clk);
    end
    ops++;
    check({msg, " latency"}, edges, LATENCY);
    check({msg, " busy in done cycle"}, busy, 0);
    check({msg, " result"}, result, want[31:0]);
    check({msg, " nv"}, flag_nv, want[34]);
    check({msg, " of"}, flag_of, want[33]);
    check({msg, " nx"}, flag_nx, want[32]);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %-20s %0d ops, %0d errors", name, ops - ops_mark, errors - err_mark);
    ops_mark = ops;
    err_mark = errors;
  endtask

  // NaN, infinity, zero or a normal value, picked at random
  function automatic logic [31:0] special_operand();
    logic [2:0]  kind;
    logic [31:0] w;
    kind = 3'(take_bits(3));
    w    = take_bits(32);
    case (kind)
      3'd0: begin
        w[30:23] = 8'hFF;
        if (w[22:0] == 0) w[0] = 1'b1;
      end
      3'd1: w[30:0] = {8'hFF, 23'd0};
      3'd2: w[30:23] = 8'd0;  // Subnormal bits read as zero
      default: if ((w[30:23] == 0) || (w[30:23] == 8'hFF)) w[30:23] = 8'd127;
    endcase
    return w;
  endfunction

  // ====================
  // Main sequence
  // ====================
  initial begin
    logic [31:0] a, b;
    {errors, checks, ops, tests, ops_mark, err_mark} = '0;
    start         = 1'b0;
    is_sub        = 1'b0;
    rounding_mode = 3'd0;
    operand_a     = '0;
    operand_b     = '0;
    @(posedge reset_n);
    @(negedge clk);
    check("busy after reset", busy, 0);
    check("done after reset", done, 0);
    check("result after reset", result, 0);
    check("flags after reset", {flag_nv, flag_of, flag_nx}, 0);
    run_op(32'h3FC0_0000, 32'h4020_0000, 1'b0, fp_round_pkg::RM_RNE, 1'b0);
    check("1.5 + 2.5", result, 32'h4080_0000);
    @(negedge clk);
    check("done width", done, 0);
    end_test("reset_timing");

    for (int i = 0; i < N_RANDOM; i++) begin
      a = take_bits(32);
      b = take_bits(32);
      a[30:23] = 8'd64 + 8'(take_bits(7));  // Band clear of overflow
      if (take_bits(1) != 0) b[30:23] = a[30:23] - 8'd8 + 8'(take_bits(4));
      else b[30:23] = 8'd64 + 8'(take_bits(7));
      run_op(a, b, 1'(take_bits(1)), 3'(take_bits(3)), 1'b0);
    end
    end_test("random_normal");

    for (int rm = 0; rm < 5; rm++) begin
      a = take_bits(32);
      a[30:23] = 8'd100;
      run_op(a, a, 1'b1, 3'(rm), 1'b0);
      run_op(a, a ^ 32'h8000_0000, 1'b0, 3'(rm), 1'b0);
      foreach (shift_list[i]) begin
        b = take_bits(32);
        b[30:23] = 8'(100 - shift_list[i]);
        run_op(a, b, 1'b0, 3'(rm), 1'b0);
        run_op(a, b, 1'b1, 3'(rm), 1'b0);
      end
    end
    end_test("cancel_align");

    for (int i = 0; i < N_SPECIAL; i++) begin
      a = special_operand();
      b = special_operand();
      run_op(a, b, 1'(take_bits(1)), 3'(take_bits(3) % 5), 1'b0);
    end
    end_test("special_values");

    for (int rm = 0; rm < 5; rm++) begin
      foreach (edge_a[i]) begin
        run_op(edge_a[i], edge_b[i], i >= 3, 3'(rm), 1'b0);
        run_op(edge_a[i] ^ 32'h8000_0000, edge_b[i] ^ 32'h8000_0000, i >= 3, 3'(rm), 1'b0);
      end
    end
    end_test("overflow_underflow");

    run_op(32'h4120_0000, 32'h3F80_0000, 1'b1, fp_round_pkg::RM_RNE, 1'b1);
    repeat (8) begin
      @(negedge clk);
      check("done after ignored start", done, 0);
      check("busy after ignored start", busy, 0);
    end
    end_test("start_while_busy");

    $display("%0d tests, %0d operations, %0d checks, %0d errors", tests, ops, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Run timed out at %0t ns after %0d of %0d operations", $time, ops, TOTAL_OPS);
    $display("Something failed");
    $finish;
  end

endmodule

/* build.f */
+incdir+include
+incdir+verification
rtl/fp_format_pkg.sv
rtl/fp_round_pkg.sv
rtl/fp_add_sequencer.sv
rtl/fp_special_case.sv
rtl/fp_mag_path.sv
rtl/fp_round_pack.sv
rtl/fp_add_top.sv
verification/tb_clock_gen.sv
verification/tb_fp_add.sv

/* Bender.yml */
package:
  name: fp_add

sources:
  - include_dirs:
      - include
    files:
      - rtl/fp_format_pkg.sv
      - rtl/fp_round_pkg.sv
      - rtl/fp_add_sequencer.sv
      - rtl/fp_special_case.sv
      - rtl/fp_mag_path.sv
      - rtl/fp_round_pack.sv
      - rtl/fp_add_top.sv
  - target: test
    include_dirs:
      - include
      - verification
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_fp_add.sv
